// File: Bender.yml
package:
  name: lc3b_evict

sources:
  - files:
      - hw/lc3b_types.sv
      - hw/eviction_buffer_datapath.sv
      - hw/plru_tree.sv
      - hw/eviction_buffer_control.sv
      - hw/eviction_buffer.sv
  - target: simulation
    files:
      - sim/eviction_buffer_tb.sv

// File: hw/eviction_buffer.sv
`default_nettype none

module eviction_buffer
    import lc3b_types::*;
#(
    parameter int num_ways = 8
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    // Lower level (cache).
    input  wire logic          buf_mem_read,
    input  wire logic          buf_mem_write,
    input  wire lc3b_word      buf_mem_address,
    input  wire lc3b_cacheline buf_mem_wdata,
    output logic               buf_mem_resp,
    output lc3b_cacheline      buf_mem_rdata,

    // Higher level (memory).
    output logic               super_mem_read,
    output logic               super_mem_write,
    output lc3b_word           super_mem_address,
    output lc3b_cacheline      super_mem_wdata,
    input  wire logic          super_mem_resp,
    input  wire lc3b_cacheline super_mem_rdata
);

    lc3b_buf_action      action;
    logic [num_ways-1:0] hits;
    lc3b_way             hit_way;
    logic                full;
    lc3b_way             victim;
    logic                touch;
    lc3b_way             touch_way;
    logic                capture;

    eviction_buffer_datapath #(.num_ways(num_ways)) datapath (
        .clk, .rst_n,
        .action, .victim, .capture,
        .hits, .hit_way, .full,
        .buf_mem_address, .buf_mem_wdata, .buf_mem_rdata,
        .super_mem_rdata, .super_mem_address, .super_mem_wdata
    );

    plru_tree plru (
        .clk, .rst_n,
        .touch, .touch_way,
        .victim
    );

    eviction_buffer_control #(.num_ways(num_ways)) control (
        .clk, .rst_n,
        .buf_mem_read, .buf_mem_write, .buf_mem_resp,
        .hits, .hit_way, .full, .action, .capture,
        .victim, .touch, .touch_way,
        .super_mem_resp, .super_mem_read, .super_mem_write
    );

endmodule : eviction_buffer

`default_nettype wire

// File: hw/eviction_buffer_control.sv
`default_nettype none

module eviction_buffer_control
    import lc3b_types::*;
#(
    parameter int num_ways = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // Lower level requests.
    input  wire logic                buf_mem_read,
    input  wire logic                buf_mem_write,
    output logic                     buf_mem_resp,

    // Datapath status and commands.
    input  wire logic [num_ways-1:0] hits,
    input  wire lc3b_way             hit_way,
    input  wire logic                full,
    output lc3b_buf_action           action,
    output logic                     capture,

    // Replacement tree.
    input  wire lc3b_way             victim,
    output logic                     touch,
    output lc3b_way                  touch_way,

    // Higher level.
    input  wire logic                super_mem_resp,
    output logic                     super_mem_read,
    output logic                     super_mem_write
);

    typedef enum logic [2:0] {
        s_idle,
        s_write_back,
        s_store,
        s_miss,
        s_respond
    } state_t;

    state_t       state_q;
    state_t       state_d;
    lc3b_way      way_q;
    lc3b_way      way_d;
    lc3b_read_sel src_q;
    lc3b_read_sel src_d;
    lc3b_way      fill_q;    // Lowest free way, entries fill in order.
    logic         fill_inc;
    logic         hit;

    assign hit = |hits;

    always_comb begin
        state_d             = state_q;
        way_d               = way_q;
        src_d               = src_q;
        fill_inc            = 1'b0;
        action.load         = 1'b0;
        action.write_sel    = wsel_mem;
        action.read_src_sel = src_q;
        action.index        = way_q;
        action.valid        = 1'b1;
        action.dirty        = 1'b1;
        touch               = 1'b0;
        touch_way           = way_q;
        capture             = 1'b0;
        buf_mem_resp        = 1'b0;
        super_mem_read      = 1'b0;
        super_mem_write     = 1'b0;

        case (state_q)
            s_idle: begin
                action.read_src_sel = rsel_array;
                if (buf_mem_write) begin
                    src_d = rsel_array;
                    if (hit || !full) begin
                        way_d            = hit ? hit_way : fill_q;
                        fill_inc         = !hit;
                        action.load      = 1'b1;
                        action.write_sel = wsel_cache;
                        action.index     = way_d;
                        touch            = 1'b1;
                        touch_way        = way_d;
                        state_d          = s_respond;
                    end else begin
                        way_d   = victim;  // Tree holds still until the store.
                        state_d = s_write_back;
                    end
                end else if (buf_mem_read) begin
                    if (hit) begin
                        way_d     = hit_way;
                        src_d     = rsel_array;
                        touch     = 1'b1;
                        touch_way = hit_way;
                        state_d   = s_respond;
                    end else begin
                        src_d   = rsel_miss;
                        state_d = s_miss;
                    end
                end
            end
            s_write_back: begin
                super_mem_write = 1'b1;
                if (super_mem_resp) begin
                    state_d = s_store;
                end
            end
            s_store: begin
                action.load      = 1'b1;
                action.write_sel = wsel_cache;
                touch            = 1'b1;
                state_d          = s_respond;
            end
            s_miss: begin
                super_mem_read = 1'b1;
                capture        = super_mem_resp;
                if (super_mem_resp) begin
                    state_d = s_respond;
                end
            end
            s_respond: begin
                buf_mem_resp = 1'b1;
                state_d      = s_idle;
            end
            default: state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= s_idle;
            way_q   <= '0;
            src_q   <= rsel_array;
            fill_q  <= '0;
        end else begin
            state_q <= state_d;
            way_q   <= way_d;
            src_q   <= src_d;
            if (fill_inc) begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

endmodule : eviction_buffer_control

`default_nettype wire

// File: hw/eviction_buffer_datapath.sv
`default_nettype none

module eviction_buffer_datapath
    import lc3b_types::*;
#(
    parameter int num_ways = 8
) (
    input  wire logic           clk,
    input  wire logic           rst_n,

    // Control.
    input  wire lc3b_buf_action action,
    input  wire lc3b_way        victim,
    input  wire logic           capture,
    output logic [num_ways-1:0] hits,
    output lc3b_way             hit_way,
    output logic                full,

    // Lower level.
    input  wire lc3b_word       buf_mem_address,
    input  wire lc3b_cacheline  buf_mem_wdata,
    output lc3b_cacheline       buf_mem_rdata,

    // Higher level.
    input  wire lc3b_cacheline  super_mem_rdata,
    output lc3b_word            super_mem_address,
    output lc3b_cacheline       super_mem_wdata
);

    logic [num_ways-1:0]      valid_q;
    logic [num_ways-1:0]      dirty_q;
    lc3b_word                 addr_q [num_ways];
    lc3b_cacheline            data_q [num_ways];
    lc3b_eviction_array_entry entries [num_ways];
    lc3b_eviction_array_entry d_in;
    lc3b_cacheline            miss_q;

    // Entry to be written.
    always_comb begin
        d_in.valid = action.valid;
        d_in.dirty = action.dirty;
        d_in.addr  = buf_mem_address;
        d_in.data  = (action.write_sel == wsel_cache) ? buf_mem_wdata : super_mem_rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (action.load) begin
            valid_q[action.index] <= d_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (action.load) begin
            dirty_q[action.index] <= d_in.dirty;
            addr_q[action.index]  <= d_in.addr;
            data_q[action.index]  <= d_in.data;
        end
    end

    // Line returned by memory on a read miss.
    always_ff @(posedge clk) begin
        if (capture) begin
            miss_q <= super_mem_rdata;
        end
    end

    // Array view and tag compare.
    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            entries[i].valid = valid_q[i];
            entries[i].dirty = dirty_q[i];
            entries[i].addr  = addr_q[i];
            entries[i].data  = data_q[i];
            hits[i]          = entries[i].valid && (entries[i].addr == buf_mem_address);
        end
    end

    // At most one way can match.
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hits[i]) begin
                hit_way = lc3b_way'(i);
            end
        end
    end

    assign full = &valid_q;

    // Misses fetch the request address, write-backs send out the victim.
    always_comb begin
        if (action.read_src_sel == rsel_miss) begin
            super_mem_address = buf_mem_address;
        end else begin
            super_mem_address = entries[victim].addr;
        end
        super_mem_wdata = entries[victim].data;
    end

    always_comb begin
        if (action.read_src_sel == rsel_miss) begin
            buf_mem_rdata = miss_q;
        end else begin
            buf_mem_rdata = entries[action.index].data;
        end
    end

endmodule : eviction_buffer_datapath

`default_nettype wire

// File: hw/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0]  lc3b_word;       // Word address.
    typedef logic [127:0] lc3b_cacheline;  // One cache line.
    typedef logic [2:0]   lc3b_way;

    // Tree pseudo-LRU. Bit 0 is the root, bits 1-2 the middle level, bits 3-6 the leaves.
    // A bit of 0 points at the lower half as least recently used.
    typedef logic [6:0]   lc3b_7b_plru;

    typedef struct packed {
        logic          valid;
        logic          dirty;
        lc3b_word      addr;
        lc3b_cacheline data;
    } lc3b_eviction_array_entry;

    // Source of a line written into the array.
    typedef enum logic {
        wsel_cache = 1'b0,
        wsel_mem   = 1'b1
    } lc3b_write_sel;

    // Source of the line returned to the cache.
    typedef enum logic {
        rsel_array = 1'b0,
        rsel_miss  = 1'b1
    } lc3b_read_sel;

    typedef struct packed {
        logic          load;          // Write the indexed entry.
        lc3b_write_sel write_sel;
        lc3b_read_sel  read_src_sel;
        lc3b_way       index;
        logic          valid;
        logic          dirty;
    } lc3b_buf_action;

endpackage : lc3b_types

`default_nettype wire

// File: hw/plru_tree.sv
`default_nettype none

module plru_tree
    import lc3b_types::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    touch,
    input  wire lc3b_way touch_way,
    output lc3b_way      victim
);

    lc3b_7b_plru tree_q;
    lc3b_7b_plru tree_d;

    // Point every node on the touched path at the other half.
    always_comb begin
        tree_d = tree_q;
        if (touch) begin
            tree_d[0] = ~touch_way[2];
            if (touch_way[2]) begin
                tree_d[2] = ~touch_way[1];
            end else begin
                tree_d[1] = ~touch_way[1];
            end
            tree_d[3 + {touch_way[2], touch_way[1]}] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    // Follow the pointers from the root down to a leaf.
    always_comb begin
        victim[2] = tree_q[0];
        if (victim[2]) begin
            victim[1] = tree_q[2];
        end else begin
            victim[1] = tree_q[1];
        end
        victim[0] = tree_q[3 + {victim[2], victim[1]}];
    end

endmodule : plru_tree

`default_nettype wire

// File: lc3b_evict.f
hw/lc3b_types.sv
hw/eviction_buffer_datapath.sv
hw/plru_tree.sv
hw/eviction_buffer_control.sv
hw/eviction_buffer.sv
sim/eviction_buffer_tb.sv

// File: sim/eviction_buffer_tb.sv
`default_nettype none

module eviction_buffer_tb
    import lc3b_types::*;
();

    localparam int num_ways           = 8;
    localparam int reset_cycles       = 16;
    localparam int num_requests       = 400;
    localparam int cycles_per_request = 16;  // Up to 8 cycles of memory delay plus handshake.
    localparam int timeout_cycles     = reset_cycles + num_requests * cycles_per_request;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          buf_mem_read;
    logic          buf_mem_write;
    lc3b_word      buf_mem_address;
    lc3b_cacheline buf_mem_wdata;
    logic          buf_mem_resp;
    lc3b_cacheline buf_mem_rdata;
    logic          super_mem_read;
    logic          super_mem_write;
    lc3b_word      super_mem_address;
    lc3b_cacheline super_mem_wdata;
    logic          super_mem_resp;
    lc3b_cacheline super_mem_rdata;

    logic [15:0]              lfsr;
    lc3b_word                 pool [16];        // Small address pool, so hits are frequent.
    lc3b_eviction_array_entry model [num_ways];
    lc3b_7b_plru              model_tree;
    lc3b_cacheline            mem_lines [lc3b_word];
    int                       cycle_count = 0;
    int                       n_evict = 0;
    int                       n_hit = 0;
    int                       n_miss = 0;

    eviction_buffer #(.num_ways(num_ways)) UUT (
        .clk, .rst_n,
        .buf_mem_read, .buf_mem_write, .buf_mem_address, .buf_mem_wdata,
        .buf_mem_resp, .buf_mem_rdata,
        .super_mem_read, .super_mem_write, .super_mem_address, .super_mem_wdata,
        .super_mem_resp, .super_mem_rdata
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("Error at %0t: run did not end within %0d cycles", $time, timeout_cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_line(input string name, input lc3b_cacheline got,
                              input lc3b_cacheline exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[126:0], lfsr_step()};
        end
        return r;
    endfunction

    // Lines never written back hold a pattern of their address.
    function automatic lc3b_cacheline mem_line(input lc3b_word addr);
        if (mem_lines.exists(addr)) begin
            return mem_lines[addr];
        end
        return {4{addr, ~addr}} ^ {8{16'h5a3c}};
    endfunction

    function automatic int model_find(input lc3b_word addr);
        for (int i = 0; i < num_ways; i++) begin
            if (model[i].valid && model[i].addr == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int model_free_way();
        for (int i = 0; i < num_ways; i++) begin
            if (!model[i].valid) begin
                return i;
            end
        end
        return -1;
    endfunction

    // A set bit names the upper half as least recently used.
    function automatic lc3b_way model_victim();
        lc3b_way v;
        v[2] = model_tree[0];
        v[1] = model_tree[1 + v[2]];
        v[0] = model_tree[3 + 2 * v[2] + v[1]];
        return v;
    endfunction

    function automatic void model_touch(input lc3b_way w);
        model_tree[0]                   = ~w[2];
        model_tree[1 + w[2]]            = ~w[1];
        model_tree[3 + 2 * w[2] + w[1]] = ~w[0];
    endfunction

    // One cache request, with the memory side served in the same loop.
    task automatic run_request(input logic is_write, input lc3b_word addr,
                               input lc3b_cacheline wdata);
        int            hit_w;
        int            way;
        logic          evict;
        lc3b_cacheline exp_data;
        int            cyc;
        int            first_mem_cyc;
        int            mem_resp_cyc;
        int            mem_wait;
        logic          mem_busy;
        int            n_reads;
        int            n_writes;
        lc3b_word      mem_addr;
        lc3b_cacheline mem_wdata;

        hit_w    = model_find(addr);
        way      = hit_w;
        evict    = 1'b0;
        exp_data = (hit_w >= 0) ? model[hit_w].data : mem_line(addr);
        if (is_write && way < 0) begin
            way = model_free_way();
            if (way < 0) begin
                way   = model_victim();
                evict = 1'b1;
            end
        end
        cyc           = 0;
        first_mem_cyc = -1;
        mem_resp_cyc  = -1;
        mem_wait      = 0;
        mem_busy      = 1'b0;
        n_reads       = 0;
        n_writes      = 0;
        mem_addr      = '0;
        mem_wdata     = '0;

        buf_mem_read    = !is_write;
        buf_mem_write   = is_write;
        buf_mem_address = addr;
        buf_mem_wdata   = wdata;
        forever begin
            @(negedge clk);
            cyc++;
            super_mem_resp = 1'b0;  // One-cycle pulse.
            if (buf_mem_resp) begin
                break;
            end
            if (super_mem_read && super_mem_write) begin
                report_error("memory read and write raised together");
            end
            if (!mem_busy && (super_mem_read || super_mem_write)) begin
                mem_busy = 1'b1;
                mem_wait = int'(rand_bits(3));
                if (first_mem_cyc < 0) begin
                    first_mem_cyc = cyc;
                end
            end
            if (mem_busy && mem_wait == 0) begin
                mem_busy       = 1'b0;
                super_mem_resp = 1'b1;
                mem_resp_cyc   = cyc;
                mem_addr       = super_mem_address;
                if (super_mem_write) begin
                    n_writes++;
                    mem_wdata = super_mem_wdata;
                end else begin
                    n_reads++;
                    super_mem_rdata = mem_line(super_mem_address);
                end
            end else if (mem_busy) begin
                mem_wait--;
            end
        end
        buf_mem_read  = 1'b0;
        buf_mem_write = 1'b0;

        if (!is_write) begin
            check_line("buf_mem_rdata", buf_mem_rdata, exp_data);
        end
        if (hit_w >= 0 || (is_write && !evict)) begin
            if (n_reads + n_writes != 0) begin
                report_error("memory was accessed on a hit or a write into a free way");
            end
            if (cyc != 1) begin
                report_error($sformatf("response came after %0d cycles instead of 1", cyc));
            end
        end else begin
            if (first_mem_cyc != 1) begin
                report_error("memory request did not start one cycle after the request");
            end
            if (evict) begin
                if (n_writes != 1 || n_reads != 0) begin
                    report_error("eviction did not cause exactly one memory write");
                end
                check_word("super_mem_address", mem_addr, model[way].addr);
                check_line("super_mem_wdata", mem_wdata, model[way].data);
                mem_lines[model[way].addr] = model[way].data;
                if (cyc != mem_resp_cyc + 2) begin
                    report_error("write response not two cycles after the memory response");
                end
            end else begin
                if (n_reads != 1 || n_writes != 0) begin
                    report_error("read miss did not cause exactly one memory read");
                end
                check_word("super_mem_address", mem_addr, addr);
                if (cyc != mem_resp_cyc + 1) begin
                    report_error("read miss response not one cycle after the memory response");
                end
            end
        end

        if (is_write) begin
            model[way] = '{valid: 1'b1, dirty: 1'b1, addr: addr, data: wdata};
            model_touch(lc3b_way'(way));
            n_evict += evict;
        end else if (hit_w >= 0) begin
            model_touch(lc3b_way'(hit_w));
            n_hit++;
        end else begin
            n_miss++;  // Misses leave the array and the tree alone.
        end
    endtask

    initial begin
        lc3b_word      addr;
        lc3b_cacheline data;
        logic [11:0]   upper;
        logic          is_write;

        lfsr            = 16'd23;
        rst_n           = 1'b0;
        buf_mem_read    = 1'b0;
        buf_mem_write   = 1'b0;
        buf_mem_address = '0;
        buf_mem_wdata   = '0;
        super_mem_resp  = 1'b0;
        super_mem_rdata = '0;
        model_tree      = '0;
        for (int i = 0; i < num_ways; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            upper   = 12'(rand_bits(12));
            pool[i] = {upper, 4'(i)};
        end

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (buf_mem_resp || super_mem_read || super_mem_write) begin
            report_error("handshake outputs are not low after reset");
        end

        for (int n = 0; n < num_requests; n++) begin
            is_write = lfsr_step();
            if (n == 0) begin
                is_write = 1'b0;  // First access is a read of an empty buffer.
            end
            addr = pool[int'(rand_bits(4))];
            data = rand_bits(128);
            run_request(is_write, addr, data);
            @(negedge clk);
        end

        if (n_evict == 0 || n_hit == 0 || n_miss == 0) begin
            $display("Error: the run saw no read hit, no read miss or no eviction");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule : eviction_buffer_tb

`default_nettype wire
